//--- src/raster_params.svh
// ~~~~~~~~~~~~~~~~~~~~
// Sizing macros for the rasterizer front end:
// FIFO depths, output credits and field widths.
// ~~~~~~~~~~~~~~~~~~~~

`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

// Buffer depths, which are also the writers' initial credits.
`define CMD_FIFO_DEPTH 8
`define TRI_FIFO_DEPTH 4

`define OUT_CREDITS 2 // Credits toward the rasterizer.

`define COORD_W 16 // Coordinate width.
`define TEX_W 8 // Texture number width.
`define CNT_W 16 // Per-frame triangle count width.

`endif

//--- src/raster_cmd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Host command protocol: opcode enumeration
// and the header, vertex and generic word views.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "raster_params.svh"

package raster_cmd_pkg;

	typedef enum logic [3:0] {
		NOP       = 4'd0,
		TRIANGLE  = 4'd1,
		FRAME_END = 4'd2
	} raster_opcode_e;

	// Generic word as it travels through the command FIFO.
	typedef struct packed {
		raster_opcode_e opcode;
		logic [27:0]    payload;
	} cmd_word_t;

	typedef struct packed {
		raster_opcode_e         opcode;
		logic [27-`TEX_W:0]     reserved; // Ignored by the decoder.
		logic [`TEX_W-1:0]      tex;
	} cmd_header_t;

	typedef struct packed {
		logic [`COORD_W-1:0] x; // Upper half.
		logic [`COORD_W-1:0] y; // Lower half.
	} cmd_vertex_t;

endpackage

`default_nettype wire

//--- src/raster_geom_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Geometry records: vertex, triangle,
// triangle queue item and setup result.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "raster_params.svh"

package raster_geom_pkg;

	typedef struct packed {
		logic [`COORD_W-1:0] x;
		logic [`COORD_W-1:0] y;
	} vertex_t;

	typedef struct packed {
		vertex_t           v0;
		vertex_t           v1;
		vertex_t           v2;
		logic [`TEX_W-1:0] tex;
	} triangle_t;

	// Queue entry; frame_end marks a frame boundary with no geometry.
	typedef struct packed {
		logic      frame_end;
		triangle_t triangle;
	} tri_item_t;

	typedef struct packed {
		logic [`COORD_W-1:0] x_min;
		logic [`COORD_W-1:0] y_min;
		logic [`COORD_W-1:0] x_max;
		logic [`COORD_W-1:0] y_max;
	} bbox_t;

	typedef struct packed {
		bbox_t             bbox;
		logic [`TEX_W-1:0] tex;
	} setup_t;

endpackage

`default_nettype wire

//--- src/credit_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// First-word-fall-through circular FIFO for any
// payload type. Each pop returns one credit to
// the writer on the following cycle.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module credit_fifo
#(
	parameter type PAYLOAD_T = logic [31:0],
	parameter int  DEPTH     = 4
)
(
	input  wire      clk,
	input  wire      reset,
	input  wire      push,
	input  PAYLOAD_T push_data,
	input  wire      pop,
	output PAYLOAD_T head,
	output logic     not_empty,
	output logic     credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int OCC_W = $clog2(DEPTH + 1);

	PAYLOAD_T mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [OCC_W-1:0] count;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0; // Wrap for any depth.
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk)
	begin
		if (reset == 1'b0)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			count  <= count + OCC_W'(push) - OCC_W'(pop);
			credit <= pop; // One credit per freed entry.
		end
	end

	assign head      = mem[rd_ptr]; // Fall-through head.
	assign not_empty = (count != '0);

endmodule

`default_nettype wire

//--- src/triangle_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~
// Command decoder: waits for and latches the
// header and three vertex words, then pushes a
// triangle item or frame marker on a credit.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "raster_params.svh"

module triangle_decoder
	import raster_cmd_pkg::*;
	import raster_geom_pkg::*;
(
	input  wire       clk,
	input  wire       reset,
	input  cmd_word_t cmd_head,
	input  wire       cmd_valid,
	output logic      cmd_pop,
	input  wire       tri_credit,
	output logic      tri_push,
	output tri_item_t tri_item
);

	localparam int CRED_W = $clog2(`TRI_FIFO_DEPTH + 1);

	typedef enum logic [2:0] {
		IDLE,
		VERTEX1,
		VERTEX2,
		VERTEX3,
		PUSH
	} state_e;

	state_e state;
	state_e next_state;

	cmd_header_t       hdr;
	logic [CRED_W-1:0] credit_cnt;
	tri_item_t         item_q;

	function automatic vertex_t to_vertex(input cmd_word_t w);
		cmd_vertex_t cv;
		vertex_t     v;
		cv  = cmd_vertex_t'(w);
		v.x = cv.x;
		v.y = cv.y;
		return v;
	endfunction

	assign hdr = cmd_header_t'(cmd_head); // Header view of the head word.

	always_ff @(posedge clk)
	begin
		if (reset == 1'b0)
		begin
			state      <= IDLE;
			credit_cnt <= CRED_W'(`TRI_FIFO_DEPTH); // Queue starts empty.
		end
		else
		begin
			state      <= next_state;
			credit_cnt <= credit_cnt + CRED_W'(tri_credit) - CRED_W'(tri_push);
		end
	end

	always_comb
	begin
		next_state = state;
		cmd_pop    = 1'b0;
		tri_push   = 1'b0;

		case (state)
			IDLE:
				if (cmd_valid)
				begin
					cmd_pop = 1'b1; // Unknown opcodes are simply dropped.
					if (hdr.opcode == TRIANGLE)
						next_state = VERTEX1;
					else if (hdr.opcode == FRAME_END)
						next_state = PUSH;
				end
			VERTEX1:
				if (cmd_valid)
				begin
					cmd_pop    = 1'b1;
					next_state = VERTEX2;
				end
			VERTEX2:
				if (cmd_valid)
				begin
					cmd_pop    = 1'b1;
					next_state = VERTEX3;
				end
			VERTEX3:
				if (cmd_valid)
				begin
					cmd_pop    = 1'b1;
					next_state = PUSH;
				end
			PUSH:
				if (credit_cnt != '0) // Hold the item until the queue has room.
				begin
					tri_push   = 1'b1;
					next_state = IDLE;
				end
			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (cmd_pop)
		begin
			case (state)
				IDLE:
				begin
					item_q.frame_end    <= (hdr.opcode == FRAME_END);
					item_q.triangle.tex <= hdr.tex;
				end
				VERTEX1: item_q.triangle.v0 <= to_vertex(cmd_head);
				VERTEX2: item_q.triangle.v1 <= to_vertex(cmd_head);
				VERTEX3: item_q.triangle.v2 <= to_vertex(cmd_head);
				default: ;
			endcase
		end
	end

	assign tri_item = item_q;

endmodule

`default_nettype wire

//--- src/bbox_setup.sv
// ~~~~~~~~~~~~~~~~~~~~
// Setup stage: bounding box per triangle,
// per-frame triangle count, output credits.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "raster_params.svh"

module bbox_setup
	import raster_geom_pkg::*;
(
	input  wire                    clk,
	input  wire                    reset,
	input  tri_item_t              item,
	input  wire                    item_valid,
	output logic                   item_pop,
	input  wire                    setup_credit,
	output logic                   setup_valid,
	output setup_t                 setup_data,
	output logic                   frame_done,
	output logic [`CNT_W-1:0]      frame_tri_count
);

	localparam int CRED_W = $clog2(`OUT_CREDITS + 1);

	typedef logic [`COORD_W-1:0] coord_t;

	logic [CRED_W-1:0] credit_cnt;
	logic [`CNT_W-1:0] tri_count;
	bbox_t             bbox;

	function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
		coord_t m;
		m = (a < b) ? a : b;
		return (c < m) ? c : m;
	endfunction

	function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
		coord_t m;
		m = (a > b) ? a : b;
		return (c > m) ? c : m;
	endfunction

	// Unsigned per-axis extents.
	always_comb
	begin
		bbox.x_min = min3(item.triangle.v0.x, item.triangle.v1.x, item.triangle.v2.x);
		bbox.y_min = min3(item.triangle.v0.y, item.triangle.v1.y, item.triangle.v2.y);
		bbox.x_max = max3(item.triangle.v0.x, item.triangle.v1.x, item.triangle.v2.x);
		bbox.y_max = max3(item.triangle.v0.y, item.triangle.v1.y, item.triangle.v2.y);
	end

	assign item_pop = item_valid && (credit_cnt != '0);

	always_ff @(posedge clk)
	begin
		if (reset == 1'b0)
		begin
			credit_cnt      <= CRED_W'(`OUT_CREDITS);
			tri_count       <= '0;
			setup_valid     <= 1'b0;
			frame_done      <= 1'b0;
			frame_tri_count <= '0;
		end
		else
		begin
			credit_cnt  <= credit_cnt + CRED_W'(setup_credit) - CRED_W'(item_pop);
			setup_valid <= item_pop && !item.frame_end;
			frame_done  <= item_pop && item.frame_end; // Markers spend a credit too.
			if (item_pop)
			begin
				if (item.frame_end)
				begin
					frame_tri_count <= tri_count;
					tri_count       <= '0; // Next frame starts from zero.
				end
				else
					tri_count <= tri_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (item_pop && !item.frame_end)
		begin
			setup_data.bbox <= bbox;
			setup_data.tex  <= item.triangle.tex;
		end
	end

endmodule

`default_nettype wire

//--- src/raster_front_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Rasterizer front end: command FIFO, decoder,
// triangle queue and bounding box setup.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "raster_params.svh"

module raster_front_top
	import raster_cmd_pkg::*;
	import raster_geom_pkg::*;
(
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    cmd_push,
	input  cmd_word_t              cmd_word,
	output logic                   cmd_credit,
	input  wire                    setup_credit,
	output logic                   setup_valid,
	output setup_t                 setup_data,
	output logic                   frame_done,
	output logic [`CNT_W-1:0]      frame_tri_count
);

	cmd_word_t cmd_head;
	logic      cmd_not_empty;
	logic      cmd_pop;

	tri_item_t tri_push_item;
	tri_item_t tri_head;
	logic      tri_push;
	logic      tri_not_empty;
	logic      tri_pop;
	logic      tri_credit;

	credit_fifo #(.PAYLOAD_T(cmd_word_t), .DEPTH(`CMD_FIFO_DEPTH)) u_cmd_fifo (
		.clk(clk), .reset(reset),
		.push(cmd_push), .push_data(cmd_word),
		.pop(cmd_pop), .head(cmd_head),
		.not_empty(cmd_not_empty), .credit(cmd_credit) // Credits go back to the host.
	);

	triangle_decoder u_decoder (
		.clk(clk), .reset(reset),
		.cmd_head(cmd_head), .cmd_valid(cmd_not_empty), .cmd_pop(cmd_pop),
		.tri_credit(tri_credit), .tri_push(tri_push), .tri_item(tri_push_item)
	);

	credit_fifo #(.PAYLOAD_T(tri_item_t), .DEPTH(`TRI_FIFO_DEPTH)) u_tri_queue (
		.clk(clk), .reset(reset),
		.push(tri_push), .push_data(tri_push_item),
		.pop(tri_pop), .head(tri_head),
		.not_empty(tri_not_empty), .credit(tri_credit)
	);

	bbox_setup u_setup (
		.clk(clk), .reset(reset),
		.item(tri_head), .item_valid(tri_not_empty), .item_pop(tri_pop),
		.setup_credit(setup_credit), .setup_valid(setup_valid), .setup_data(setup_data),
		.frame_done(frame_done), .frame_tri_count(frame_tri_count)
	);

endmodule

`default_nettype wire

//--- testbench/raster_front_assert.sv
// ~~~~~~~~~~~~~~~~~~~~
// Credit FIFO protocol assertions and their bind.
// They forbid a pop when empty, a push when full
// and a credit without a freed entry.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module raster_front_assert
#(
	parameter int DEPTH = 4
)
(
	input wire                         clk,
	input wire                         reset,
	input wire                         push,
	input wire                         pop,
	input wire                         not_empty,
	input wire                         credit,
	input wire [$clog2(DEPTH + 1)-1:0] count
);

	int fail_count = 0; // Number of failed assertions.

	assert property (@(posedge clk) disable iff (reset == 1'b0) pop |-> not_empty)
	else
	begin
		$error("credit FIFO popped while empty");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (reset == 1'b0) push |-> (count != DEPTH))
	else
	begin
		$error("credit FIFO pushed while full");
		fail_count++;
	end

	// A credit is only returned for an entry that really left the FIFO.
	assert property (@(posedge clk) disable iff (reset == 1'b0)
			credit |-> $past(pop && not_empty))
	else
	begin
		$error("credit FIFO returned a credit without freeing an entry");
		fail_count++;
	end

endmodule

bind credit_fifo raster_front_assert #(.DEPTH(DEPTH)) u_fifo_assert (
	.clk(clk), .reset(reset), .push(push), .pop(pop),
	.not_empty(not_empty), .credit(credit), .count(count)
);

`default_nettype wire

//--- testbench/raster_front_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the rasterizer front end with
// clock, reset, credited host and sink models,
// bounding box reference, directed tests,
// value checker, watchdog and summary.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "raster_params.svh"

module raster_front_tb
	import raster_cmd_pkg::*;
	import raster_geom_pkg::*;
();

	localparam int CYCLES_PER_WORD = 20;
	localparam int N_RANDOM        = 6;
	localparam int N_PRESSURE      = 10; // Enough words to overrun every buffer.
	localparam int HOLD_CYCLES     = 60;

	logic              clk = 1'b0;
	logic              reset;
	logic              cmd_push;
	cmd_word_t         cmd_word;
	logic              cmd_credit;
	logic              setup_credit;
	logic              setup_valid;
	setup_t            setup_data;
	logic              frame_done;
	logic [`CNT_W-1:0] frame_tri_count;

	cmd_word_t         host_queue [$];
	setup_t            exp_setup [$];
	setup_t            got_setup [$];
	logic [`CNT_W-1:0] exp_frames [$];
	logic [`CNT_W-1:0] got_frames [$];

	int          host_credits;
	int          words_pushed;
	int          credits_returned;
	int          words_total;
	int          owed_credits;
	int          checks;
	int          errors;
	int          cycle_count;
	bit          sink_enable;
	logic [31:0] rng_state;

	always #20 clk = ~clk;

	raster_front_top u_dut (
		.clk(clk), .reset(reset),
		.cmd_push(cmd_push), .cmd_word(cmd_word), .cmd_credit(cmd_credit),
		.setup_credit(setup_credit), .setup_valid(setup_valid), .setup_data(setup_data),
		.frame_done(frame_done), .frame_tri_count(frame_tri_count)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Reference model of the unsigned per-axis extremes.
	function automatic setup_t expected_setup(input triangle_t t);
		logic [`COORD_W-1:0] xs [3];
		logic [`COORD_W-1:0] ys [3];
		setup_t              s;
		int                  i;
		xs[0] = t.v0.x;
		xs[1] = t.v1.x;
		xs[2] = t.v2.x;
		ys[0] = t.v0.y;
		ys[1] = t.v1.y;
		ys[2] = t.v2.y;
		s.bbox = {xs[0], ys[0], xs[0], ys[0]};
		for (i = 1; i < 3; i++)
		begin
			if (xs[i] < s.bbox.x_min) s.bbox.x_min = xs[i];
			if (xs[i] > s.bbox.x_max) s.bbox.x_max = xs[i];
			if (ys[i] < s.bbox.y_min) s.bbox.y_min = ys[i];
			if (ys[i] > s.bbox.y_max) s.bbox.y_max = ys[i];
		end
		s.tex = t.tex;
		return s;
	endfunction

	task automatic check_value(input string name, input logic [71:0] got,
			input logic [71:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic random_triangle(output triangle_t t);
		logic [31:0] r [4];
		int          i;
		for (i = 0; i < 4; i++)
		begin
			rng_state = xorshift32(rng_state);
			r[i]      = rng_state;
		end
		t.v0  = vertex_t'(r[0]); // Upper half is x and lower half is y.
		t.v1  = vertex_t'(r[1]);
		t.v2  = vertex_t'(r[2]);
		t.tex = r[3][`TEX_W-1:0];
	endtask

	task automatic queue_word(input logic [31:0] w);
		host_queue.push_back(cmd_word_t'(w));
		words_total++;
	endtask

	task automatic queue_triangle(input triangle_t t);
		queue_word({TRIANGLE, 28'(t.tex)}); // Header with the texture in the low bits.
		queue_word(t.v0);
		queue_word(t.v1);
		queue_word(t.v2);
		exp_setup.push_back(expected_setup(t));
	endtask

	task automatic queue_frame_end(input int count);
		queue_word({FRAME_END, 28'h0});
		exp_frames.push_back(`CNT_W'(count));
	endtask

	// Host pushes one word per cycle while a credit is held.
	task automatic host_step();
		cmd_push = 1'b0;
		if (cmd_credit)
		begin
			host_credits++;
			credits_returned++;
		end
		if (host_queue.size() != 0 && host_credits > 0)
		begin
			cmd_word = host_queue.pop_front();
			cmd_push = 1'b1;
			host_credits--;
			words_pushed++;
		end
	endtask

	// Sink records results and hands back one credit per result.
	task automatic sink_step();
		setup_credit = 1'b0;
		if (setup_valid)
		begin
			got_setup.push_back(setup_data);
			owed_credits++;
		end
		if (frame_done)
		begin
			got_frames.push_back(frame_tri_count);
			owed_credits++;
		end
		if (sink_enable && owed_credits > 0)
		begin
			setup_credit = 1'b1;
			owed_credits--;
		end
	endtask

	always @(negedge clk)
	begin
		host_step();
		sink_step();
	end

	task automatic wait_for_results();
		while (got_setup.size() < exp_setup.size() || got_frames.size() < exp_frames.size())
			@(posedge clk);
	endtask

	task automatic compare_results();
		check_value("setup_valid_count", got_setup.size(), exp_setup.size());
		check_value("frame_done_count", got_frames.size(), exp_frames.size());
		while (exp_setup.size() != 0 && got_setup.size() != 0)
			check_value("setup_data", got_setup.pop_front(), exp_setup.pop_front());
		while (exp_frames.size() != 0 && got_frames.size() != 0)
			check_value("frame_tri_count", got_frames.pop_front(), exp_frames.pop_front());
		exp_setup.delete();
		got_setup.delete();
		exp_frames.delete();
		got_frames.delete();
	endtask

	task automatic report_test(input string name, input int start_errors);
		$display("%s finished with %0d errors", name, errors - start_errors);
	endtask

	task automatic verify_reset_state();
		int start;
		start = errors;
		@(negedge clk);
		check_value("setup_valid", setup_valid, 1'b0);
		check_value("frame_done", frame_done, 1'b0);
		check_value("cmd_credit", cmd_credit, 1'b0);
		@(posedge clk);
		report_test("reset_state", start);
	endtask

	task automatic single_triangle_frame();
		triangle_t t;
		int        start;
		start = errors;
		t.v0  = {16'd100, 16'd20};
		t.v1  = {16'd30, 16'd250};
		t.v2  = {16'd400, 16'd90};
		t.tex = 8'h5a;
		queue_triangle(t);
		queue_frame_end(1);
		wait_for_results();
		compare_results();
		report_test("single_triangle", start);
	endtask

	task automatic back_to_back_frame();
		triangle_t t;
		int        start;
		int        i;
		start = errors;
		for (i = 0; i < N_RANDOM; i++)
		begin
			random_triangle(t);
			queue_triangle(t);
		end
		queue_frame_end(N_RANDOM);
		wait_for_results();
		compare_results();
		report_test("random_frame", start);
	endtask

	task automatic dropped_opcode_frame();
		triangle_t t;
		int        start;
		start = errors;
		random_triangle(t);
		queue_triangle(t);
		queue_word({NOP, 28'h0});
		random_triangle(t);
		queue_triangle(t);
		queue_word({4'hf, 28'habcdef}); // Unknown opcodes with a payload.
		queue_word({4'h7, 28'h0});
		random_triangle(t);
		queue_triangle(t);
		queue_frame_end(3);
		wait_for_results();
		compare_results();
		report_test("dropped_opcodes", start);
	endtask

	task automatic back_pressure_release();
		triangle_t t;
		int        start;
		int        i;
		start = errors;
		while (owed_credits != 0)
			@(posedge clk);
		sink_enable = 1'b0;
		for (i = 0; i < N_PRESSURE; i++)
		begin
			random_triangle(t);
			queue_triangle(t);
		end
		queue_frame_end(N_PRESSURE);
		while (got_setup.size() < `OUT_CREDITS)
			@(posedge clk);
		repeat (HOLD_CYCLES) @(posedge clk); // Let the stall reach the host.
		check_value("result_count", got_setup.size() + got_frames.size(), `OUT_CREDITS);
		check_value("host_credits", host_credits, 0);
		check_value("host_stalled", host_queue.size() != 0, 1'b1);
		sink_enable = 1'b1;
		wait_for_results();
		compare_results();
		report_test("back_pressure", start);
	endtask

	task automatic credit_return_balance();
		int start;
		start = errors;
		repeat (4) @(posedge clk);
		check_value("cmd_credit_total", credits_returned, words_pushed);
		check_value("host_credits", host_credits, `CMD_FIFO_DEPTH);
		report_test("credit_return", start);
	endtask

	initial
	begin
		reset            = 1'b0;
		cmd_push         = 1'b0;
		cmd_word         = '0;
		setup_credit     = 1'b0;
		host_credits     = `CMD_FIFO_DEPTH;
		words_pushed     = 0;
		credits_returned = 0;
		words_total      = 0;
		owed_credits     = 0;
		checks           = 0;
		errors           = 0;
		sink_enable      = 1'b1;
		rng_state        = 32'd59584;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
		verify_reset_state();
		single_triangle_frame();
		back_to_back_frame();
		dropped_opcode_frame();
		back_pressure_release();
		credit_return_balance();
		check_value("assert_failures",
			u_dut.u_cmd_fifo.u_fifo_assert.fail_count
			+ u_dut.u_tri_queue.u_fifo_assert.fail_count, 0);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Limit grows with every word queued.
	initial
	begin
		cycle_count = 0;
		while (cycle_count <= 200 + words_total * CYCLES_PER_WORD)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d clock cycles", cycle_count);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/raster_cmd_pkg.sv
src/raster_geom_pkg.sv
src/credit_fifo.sv
src/triangle_decoder.sv
src/bbox_setup.sv
src/raster_front_top.sv
testbench/raster_front_assert.sv
testbench/raster_front_tb.sv
